// File: bertChecker.sv
`timescale 1ns/1ns
`default_nettype none
`include "bert_settings.svh"

module bertChecker (
    input  logic       clk,
    input  logic       reset,
    input  logic       checkBitEn,
    input  logic       checkBit,
    bertStatusIf.check status
);

    localparam int MatchWidth  = $clog2(`BERT_LOCK_COUNT) + 1;
    localparam int WindowWidth = $clog2(`BERT_WINDOW);
    localparam int LimitWidth  = $clog2(`BERT_ERROR_LIMIT) + 1;

    bertPkg::lockState_t    state;
    bertPkg::pnState_t      history;
    bertPkg::counter_t      bitCount;
    bertPkg::counter_t      errorCount;
    logic [MatchWidth-1:0]  matchCount;
    logic [WindowWidth-1:0] windowCount;
    logic [LimitWidth-1:0]  windowErrors;
    logic [LimitWidth-1:0]  windowErrorsNext;
    logic                   mismatch;

    // Prediction from the received bits 14 and 15 back
    assign mismatch         = checkBit ^ history[13] ^ history[14];
    assign windowErrorsNext = windowErrors + LimitWidth'(mismatch);

    assign status.locked     = (state == bertPkg::LOCKED);
    assign status.bitCount   = bitCount;
    assign status.errorCount = errorCount;

    always_ff @(posedge clk) begin
        if (checkBitEn) begin
            history <= {history[13:0], checkBit};
        end
    end

//**********************************************************************
//  Lock FSM
//**********************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= bertPkg::HUNTING;
            matchCount   <= '0;
            windowCount  <= '0;
            windowErrors <= '0;
        end else if (checkBitEn) begin
            case (state)
                bertPkg::LOCKED: begin
                    if (windowErrorsNext == LimitWidth'(`BERT_ERROR_LIMIT)) begin
                        state        <= bertPkg::HUNTING;
                        windowCount  <= '0;
                        windowErrors <= '0;
                    end else if (windowCount == WindowWidth'(`BERT_WINDOW - 1)) begin
                        windowCount  <= '0;
                        windowErrors <= '0;
                    end else begin
                        windowCount  <= windowCount + WindowWidth'(1);
                        windowErrors <= windowErrorsNext;
                    end
                end
                default: begin
                    // Any miss restarts the run of matches
                    if (mismatch) begin
                        matchCount <= '0;
                    end else if (matchCount == MatchWidth'(`BERT_LOCK_COUNT - 1)) begin
                        matchCount <= '0;
                        state      <= bertPkg::LOCKED;
                    end else begin
                        matchCount <= matchCount + MatchWidth'(1);
                    end
                end
            endcase
        end
    end

    // Bits and errors counted only while locked
    always_ff @(posedge clk) begin
        if (reset || status.clearCounters) begin
            bitCount   <= '0;
            errorCount <= '0;
        end else if (checkBitEn && (state == bertPkg::LOCKED)) begin
            bitCount   <= bitCount + bertPkg::counter_t'(1);
            errorCount <= errorCount + bertPkg::counter_t'(mismatch);
        end
    end

endmodule

`default_nettype wire

// File: bertIfs.sv
`timescale 1ns/1ns
`default_nettype none

// Generator control and FIFO run state
interface pnCtrlIf;
    logic              pnEnable;
    bertPkg::divider_t pnRate;
    logic              injectError;
    logic              fifoRunning;

    modport regs (
        output pnEnable,
        output pnRate,
        output injectError,
        input  fifoRunning
    );
    modport gen (
        input  pnEnable,
        input  pnRate,
        input  injectError
    );
    modport fifo (
        output fifoRunning
    );
endinterface

// Checker results and counter clear
interface bertStatusIf;
    logic              clearCounters;
    bertPkg::counter_t bitCount;
    bertPkg::counter_t errorCount;
    logic              locked;

    modport regs (
        output clearCounters,
        input  bitCount,
        input  errorCount,
        input  locked
    );
    modport check (
        input  clearCounters,
        output bitCount,
        output errorCount,
        output locked
    );
endinterface

`default_nettype wire

// File: bertPkg.sv
`default_nettype none
`include "bert_settings.svh"

package bertPkg;

    typedef logic [`BERT_DATA_WIDTH-1:0] regData_t;
    typedef logic [`BERT_ADDR_WIDTH-1:0] regAddr_t;
    typedef logic [`BERT_DIV_WIDTH-1:0]  divider_t;

    // Counters are read back as whole register words
    typedef logic [`BERT_DATA_WIDTH-1:0] counter_t;

    typedef logic [`BERT_PN_ORDER-1:0]            pnState_t;
    typedef logic [$clog2(`BERT_FIFO_DEPTH)-1:0]  fifoPtr_t;
    typedef logic [$clog2(`BERT_FIFO_DEPTH):0]    fifoCount_t;

    typedef enum logic [1:0] {
        SRC_PN_RAW   = 2'd0,
        SRC_SMOOTHED = 2'd1,
        SRC_EXTERNAL = 2'd2,
        SRC_NONE     = 2'd3
    } sourceSel_t;

    typedef enum logic {
        HUNTING = 1'b0,
        LOCKED  = 1'b1
    } lockState_t;

endpackage

`default_nettype wire

// File: bertRegs.sv
`timescale 1ns/1ns
`default_nettype none
`include "bert_settings.svh"

module bertRegs (
    input  logic                clk,
    input  logic                reset,
    input  bertPkg::regAddr_t   regAddr,
    input  logic                regWrite,
    input  logic                regRead,
    input  bertPkg::regData_t   regWriteData,
    output bertPkg::regData_t   regReadData,
    pnCtrlIf.regs               pnCtrl,
    bertStatusIf.regs           status,
    output bertPkg::divider_t   drainRate,
    output bertPkg::sourceSel_t checkSource,
    output bertPkg::sourceSel_t lineSource
);

    logic              pnEnable;
    logic              clearPulse;
    logic              injectPulse;
    logic              controlWrite;
    bertPkg::divider_t pnRate;
    bertPkg::regData_t readMux;

    assign controlWrite = regWrite && (regAddr == `REG_CONTROL);

    // Counters clear at the edge that takes the write
    assign clearPulse   = controlWrite && regWriteData[1];

    assign pnCtrl.pnEnable     = pnEnable;
    assign pnCtrl.pnRate       = pnRate;
    assign pnCtrl.injectError  = injectPulse;
    assign status.clearCounters = clearPulse;

//**********************************************************************
//  Register writes
//**********************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            pnEnable    <= 1'b0;
            injectPulse <= 1'b0;
            pnRate      <= '0;
            drainRate   <= '0;
            checkSource <= bertPkg::SRC_PN_RAW;
            lineSource  <= bertPkg::SRC_PN_RAW;
        end else begin
            // Bit 2 acts for one cycle only
            injectPulse <= controlWrite && regWriteData[2];
            if (controlWrite) begin
                pnEnable    <= regWriteData[0];
                checkSource <= bertPkg::sourceSel_t'(regWriteData[5:4]);
                lineSource  <= bertPkg::sourceSel_t'(regWriteData[7:6]);
            end
            if (regWrite && (regAddr == `REG_PN_RATE)) begin
                pnRate <= regWriteData[`BERT_DIV_WIDTH-1:0];
            end
            if (regWrite && (regAddr == `REG_DRAIN_RATE)) begin
                drainRate <= regWriteData[`BERT_DIV_WIDTH-1:0];
            end
        end
    end

//**********************************************************************
//  Read-back mux
//**********************************************************************
    always_comb begin
        readMux = '0;
        case (regAddr)
            `REG_VERSION:     readMux = bertPkg::regData_t'(`BERT_VERSION);
            `REG_CONTROL: begin
                readMux[0]   = pnEnable;
                readMux[5:4] = checkSource;
                readMux[7:6] = lineSource;
            end
            `REG_PN_RATE:     readMux = bertPkg::regData_t'(pnRate);
            `REG_DRAIN_RATE:  readMux = bertPkg::regData_t'(drainRate);
            `REG_BIT_COUNT:   readMux = status.bitCount;
            `REG_ERROR_COUNT: readMux = status.errorCount;
            `REG_STATUS: begin
                readMux[0] = status.locked;
                readMux[1] = pnCtrl.fifoRunning;
            end
            default:          readMux = '0;
        endcase
    end

    // Held until the next read
    always_ff @(posedge clk) begin
        if (regRead) begin
            regReadData <= readMux;
        end
    end

    clearIsPulse: assert property (@(posedge clk) disable iff (reset)
        status.clearCounters |=> !status.clearCounters)
        else $error("clearCounters held for two cycles");

    injectIsPulse: assert property (@(posedge clk) disable iff (reset)
        pnCtrl.injectError |=> !pnCtrl.injectError)
        else $error("injectError held for two cycles");

endmodule

`default_nettype wire

// File: bertRouter.sv
`timescale 1ns/1ns
`default_nettype none

module bertRouter (
    input  logic                clk,
    input  logic                reset,
    input  bertPkg::sourceSel_t checkSource,
    input  bertPkg::sourceSel_t lineSource,
    input  logic                pnBitEn,
    input  logic                pnBit,
    input  logic                smoothBitEn,
    input  logic                smoothBit,
    input  logic                extBitEn,
    input  logic                extBit,
    output logic                checkBitEn,
    output logic                checkBit,
    output logic                lineBitEn,
    output logic                lineBit
);

    logic [1:0] checkPick;
    logic [1:0] linePick;

    // Enable in bit 1, data in bit 0
    function automatic logic [1:0] pickSource(input bertPkg::sourceSel_t sel);
        case (sel)
            bertPkg::SRC_PN_RAW:   return {pnBitEn, pnBit};
            bertPkg::SRC_SMOOTHED: return {smoothBitEn, smoothBit};
            bertPkg::SRC_EXTERNAL: return {extBitEn, extBit};
            default:               return 2'b00;
        endcase
    endfunction

    always_comb begin
        checkPick = pickSource(checkSource);
        linePick  = pickSource(lineSource);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            checkBitEn <= 1'b0;
            lineBitEn  <= 1'b0;
        end else begin
            checkBitEn <= checkPick[1];
            lineBitEn  <= linePick[1];
        end
    end

    always_ff @(posedge clk) begin
        checkBit <= checkPick[0];
        lineBit  <= linePick[0];
    end

endmodule

`default_nettype wire

// File: bertTb.sv
`timescale 1ns/1ns
`default_nettype none
`include "bert_settings.svh"

module bertTb;

    localparam int ClkPeriod     = 20;
    localparam int ResetCycles   = 4;
    localparam int LockTimeout   = 1000;
    localparam int SettleCycles  = 200;
    localparam int StreamTimeout = 1000;
    localparam int StatusPolls   = 100;
    localparam int ExtTimeout    = 400;
    localparam int BusSlack      = 200;
    // Sum of the phase budgets
    localparam int TotalCycles = ResetCycles + 2 * LockTimeout + 2 * SettleCycles
        + 2 * StreamTimeout + 2 * StatusPolls + 3 * ExtTimeout + BusSlack;

    logic              clk;
    logic              reset;
    bertPkg::regAddr_t regAddr;
    logic              regWrite;
    logic              regRead;
    bertPkg::regData_t regWriteData;
    bertPkg::regData_t regReadData;
    logic              extBitEn;
    logic              extBit;
    logic              lineBitEn;
    logic              lineBit;
    logic              bertLocked;

    // Line stream monitor
    logic              lineWatch;
    int                lineSeen;
    bertPkg::pnState_t lineHist;
    logic              linePredicted;

    bertPkg::pnState_t extHist;
    integer            seed;

    bertTop i_dut (
        .clk(clk), .reset(reset),
        .regAddr(regAddr), .regWrite(regWrite), .regRead(regRead),
        .regWriteData(regWriteData), .regReadData(regReadData),
        .extBitEn(extBitEn), .extBit(extBit),
        .lineBitEn(lineBitEn), .lineBit(lineBit), .bertLocked(bertLocked)
    );

    always #(ClkPeriod / 2) clk = ~clk;

//**********************************************************************
//  Checking helpers
//**********************************************************************
    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic expectEqual(input string name, input bertPkg::regData_t got,
                               input bertPkg::regData_t want);
        assert (got == want) else stopWithFailure($sformatf(
            "Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want));
    endtask

    task automatic expectNonzero(input string name, input bertPkg::regData_t got);
        assert (got != '0) else stopWithFailure($sformatf(
            "Fail at %0t ns: %s = 0x%0h, expected nonzero", $time, name, got));
    endtask

    // Layout of REG_CONTROL
    function automatic bertPkg::regData_t controlWord(input logic enable, input logic clear,
            input logic inject, input bertPkg::sourceSel_t checkSrc,
            input bertPkg::sourceSel_t lineSrc);
        bertPkg::regData_t word;
        word      = '0;
        word[0]   = enable;
        word[1]   = clear;
        word[2]   = inject;
        word[5:4] = checkSrc;
        word[7:6] = lineSrc;
        return word;
    endfunction

//**********************************************************************
//  Register bus and waits entered 2 ns after a rising edge
//**********************************************************************
    task automatic busWrite(input bertPkg::regAddr_t addr, input bertPkg::regData_t data);
        regAddr      = addr;
        regWriteData = data;
        regWrite     = 1'b1;
        @(posedge clk);
        #2;
        regWrite = 1'b0;
    endtask

    task automatic busRead(input bertPkg::regAddr_t addr, output bertPkg::regData_t data);
        regAddr = addr;
        regRead = 1'b1;
        @(posedge clk);
        #2;
        regRead = 1'b0;
        data    = regReadData;
    endtask

    task automatic waitCycles(input int count);
        repeat (count) @(posedge clk);
        #2;
    endtask

    task automatic waitLocked(input logic level, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (bertLocked != level) begin
            if (cycles >= limit) stopWithFailure($sformatf("Timeout waiting for %s", what));
            waitCycles(1);
            cycles++;
        end
    endtask

    task automatic waitLineBits(input int count);
        int target;
        int cycles;
        target = lineSeen + count;
        cycles = 0;
        while (lineSeen < target) begin
            if (cycles >= StreamTimeout) stopWithFailure("Line output stopped producing bits");
            waitCycles(1);
            cycles++;
        end
    endtask

    task automatic waitFifoRunning();
        bertPkg::regData_t data;
        int                polls;
        polls = 0;
        busRead(`REG_STATUS, data);
        while (!data[1]) begin
            if (polls >= StatusPolls) stopWithFailure("REG_STATUS never showed the FIFO running");
            busRead(`REG_STATUS, data);
            polls++;
        end
    endtask

    // One external bit per cycle until the lock state reaches the target
    task automatic driveExternal(input logic useRandom, input logic targetLocked,
                                 input int limit, input string what);
        int     cycles;
        integer randWord;
        logic   newBit;
        cycles = 0;
        while (bertLocked != targetLocked) begin
            if (cycles >= limit) stopWithFailure($sformatf("Timeout waiting for %s", what));
            if (useRandom) begin
                randWord = $random(seed);
                extBit   = randWord[0];
            end else begin
                // b(n) = b(n-14) ^ b(n-15)
                newBit  = extHist[13] ^ extHist[14];
                extHist = {extHist[13:0], newBit};
                extBit  = newBit;
            end
            extBitEn = 1'b1;
            waitCycles(1);
            cycles++;
        end
        extBitEn = 1'b0;
    endtask

//**********************************************************************
//  Monitors
//**********************************************************************
    resetClears: assert property (@(posedge clk) reset |=> (!lineBitEn && !bertLocked))
        else stopWithFailure("Line enable or lock still active after a reset cycle");

    // PN15 recurrence on the line output once 15 bits are known
    always @(negedge clk) begin
        if (!lineWatch) begin
            lineSeen = 0;
        end else if (lineBitEn) begin
            linePredicted = lineHist[13] ^ lineHist[14];
            if (lineSeen >= `BERT_PN_ORDER) begin
                assert (lineBit == linePredicted) else stopWithFailure($sformatf(
                    "Fail at %0t ns: lineBit = %0b, expected %0b",
                    $time, lineBit, linePredicted));
            end
            lineHist = {lineHist[13:0], lineBit};
            lineSeen = lineSeen + 1;
        end
    end

    initial begin
        #(TotalCycles * ClkPeriod);
        stopWithFailure("Watchdog expired before the tests finished");
    end

//**********************************************************************
//  Test sequence
//**********************************************************************
    initial begin : mainSequence
        bertPkg::regData_t data;
        clk          = 1'b0;
        reset        = 1'b1;
        regAddr      = '0;
        regWrite     = 1'b0;
        regRead      = 1'b0;
        regWriteData = '0;
        extBitEn     = 1'b0;
        extBit       = 1'b0;
        lineWatch    = 1'b0;
        lineSeen     = 0;
        lineHist     = '0;
        extHist      = 15'h2D71;
        seed         = 36053;
        repeat (ResetCycles) @(posedge clk);
        #2;
        reset = 1'b0;

        // Idle outputs and version
        expectEqual("lineBitEn", bertPkg::regData_t'(lineBitEn), 32'd0);
        expectEqual("bertLocked", bertPkg::regData_t'(bertLocked), 32'd0);
        busRead(`REG_VERSION, data);
        expectEqual("REG_VERSION", data, bertPkg::regData_t'(`BERT_VERSION));

        // Lock on the raw generator
        busWrite(`REG_PN_RATE, 32'd1);
        busWrite(`REG_CONTROL, controlWord(1'b1, 1'b0, 1'b0,
                 bertPkg::SRC_PN_RAW, bertPkg::SRC_PN_RAW));
        waitLocked(1'b1, LockTimeout, "lock on the raw PN stream");
        waitCycles(SettleCycles);
        busRead(`REG_ERROR_COUNT, data);
        expectEqual("REG_ERROR_COUNT", data, 32'd0);
        busRead(`REG_BIT_COUNT, data);
        expectNonzero("REG_BIT_COUNT", data);

        // One flipped bit costs three checks
        busWrite(`REG_CONTROL, controlWord(1'b1, 1'b0, 1'b1,
                 bertPkg::SRC_PN_RAW, bertPkg::SRC_PN_RAW));
        waitCycles(SettleCycles);
        busRead(`REG_ERROR_COUNT, data);
        expectEqual("REG_ERROR_COUNT", data, 32'd3);
        expectEqual("bertLocked", bertPkg::regData_t'(bertLocked), 32'd1);

        // Smoothed path with the drain faster than the generator
        busWrite(`REG_PN_RATE, 32'd3);
        busWrite(`REG_DRAIN_RATE, 32'd1);
        busWrite(`REG_CONTROL, controlWord(1'b1, 1'b0, 1'b0,
                 bertPkg::SRC_SMOOTHED, bertPkg::SRC_SMOOTHED));
        waitCycles(1);
        lineWatch = 1'b1;
        waitLineBits(2 * `BERT_PN_ORDER);
        waitFifoRunning();
        busWrite(`REG_CONTROL, controlWord(1'b1, 1'b1, 1'b0,
                 bertPkg::SRC_SMOOTHED, bertPkg::SRC_SMOOTHED));
        waitLocked(1'b1, LockTimeout, "lock on the smoothed stream");
        waitLineBits(`BERT_WINDOW);
        busRead(`REG_ERROR_COUNT, data);
        expectEqual("REG_ERROR_COUNT", data, 32'd0);
        busRead(`REG_BIT_COUNT, data);
        expectNonzero("REG_BIT_COUNT", data);
        lineWatch = 1'b0;

        // External input drops the lock, locks on PN and drops again on noise
        busWrite(`REG_CONTROL, controlWord(1'b0, 1'b0, 1'b0,
                 bertPkg::SRC_EXTERNAL, bertPkg::SRC_NONE));
        driveExternal(1'b1, 1'b0, ExtTimeout, "random bits to drop the old lock");
        driveExternal(1'b0, 1'b1, ExtTimeout, "lock on the external PN stream");
        driveExternal(1'b1, 1'b0, ExtTimeout, "lock loss on random external bits");

        // Counter clear with no source selected
        busWrite(`REG_CONTROL, controlWord(1'b0, 1'b0, 1'b0,
                 bertPkg::SRC_NONE, bertPkg::SRC_NONE));
        waitCycles(4);
        busWrite(`REG_CONTROL, controlWord(1'b0, 1'b1, 1'b0,
                 bertPkg::SRC_NONE, bertPkg::SRC_NONE));
        busRead(`REG_BIT_COUNT, data);
        expectEqual("REG_BIT_COUNT", data, 32'd0);
        busRead(`REG_ERROR_COUNT, data);
        expectEqual("REG_ERROR_COUNT", data, 32'd0);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bertTop.sv
`timescale 1ns/1ns
`default_nettype none

module bertTop (
    input  logic              clk,
    input  logic              reset,
    input  bertPkg::regAddr_t regAddr,
    input  logic              regWrite,
    input  logic              regRead,
    input  bertPkg::regData_t regWriteData,
    output bertPkg::regData_t regReadData,
    input  logic              extBitEn,
    input  logic              extBit,
    output logic              lineBitEn,
    output logic              lineBit,
    output logic              bertLocked
);

    logic                pnBitEn;
    logic                pnBit;
    logic                credit;
    logic                smoothBitEn;
    logic                smoothBit;
    logic                checkBitEn;
    logic                checkBit;
    bertPkg::divider_t   drainRate;
    bertPkg::sourceSel_t checkSource;
    bertPkg::sourceSel_t lineSource;

    pnCtrlIf     pnCtrl ();
    bertStatusIf status ();

//**********************************************************************
//  Registers
//**********************************************************************
    bertRegs i_regs (
        .clk(clk), .reset(reset),
        .regAddr(regAddr), .regWrite(regWrite), .regRead(regRead),
        .regWriteData(regWriteData), .regReadData(regReadData),
        .pnCtrl(pnCtrl.regs), .status(status.regs),
        .drainRate(drainRate),
        .checkSource(checkSource), .lineSource(lineSource)
    );

//**********************************************************************
//  Pattern source and smoothing FIFO
//**********************************************************************
    pnGenerator i_pnGen (
        .clk(clk), .reset(reset),
        .pnCtrl(pnCtrl.gen), .credit(credit),
        .pnBitEn(pnBitEn), .pnBit(pnBit)
    );

    jitterFifo i_fifo (
        .clk(clk), .reset(reset),
        .pnBitEn(pnBitEn), .pnBit(pnBit),
        .drainRate(drainRate), .pnCtrl(pnCtrl.fifo), .credit(credit),
        .smoothBitEn(smoothBitEn), .smoothBit(smoothBit)
    );

//**********************************************************************
//  Routing and checking
//**********************************************************************
    bertRouter i_router (
        .clk(clk), .reset(reset),
        .checkSource(checkSource), .lineSource(lineSource),
        .pnBitEn(pnBitEn), .pnBit(pnBit),
        .smoothBitEn(smoothBitEn), .smoothBit(smoothBit),
        .extBitEn(extBitEn), .extBit(extBit),
        .checkBitEn(checkBitEn), .checkBit(checkBit),
        .lineBitEn(lineBitEn), .lineBit(lineBit)
    );

    bertChecker i_checker (
        .clk(clk), .reset(reset),
        .checkBitEn(checkBitEn), .checkBit(checkBit),
        .status(status.check)
    );

    assign bertLocked = status.locked;

endmodule

`default_nettype wire

// File: bert_settings.svh
`ifndef BERT_SETTINGS_SVH
`define BERT_SETTINGS_SVH

// Register bus geometry
`define BERT_DATA_WIDTH   32
`define BERT_ADDR_WIDTH   8

// Divider, FIFO and pattern sizing
`define BERT_DIV_WIDTH    16
`define BERT_FIFO_DEPTH   16
`define BERT_PN_ORDER     15

// Checker lock and unlock thresholds
`define BERT_LOCK_COUNT   32
`define BERT_ERROR_LIMIT  8
`define BERT_WINDOW       64

`define BERT_VERSION      16'd425

// Register map
`define REG_VERSION       8'h00
`define REG_CONTROL       8'h01
`define REG_PN_RATE       8'h02
`define REG_DRAIN_RATE    8'h03
`define REG_BIT_COUNT     8'h04
`define REG_ERROR_COUNT   8'h05
`define REG_STATUS        8'h06

`endif

// File: jitterFifo.sv
`timescale 1ns/1ns
`default_nettype none
`include "bert_settings.svh"

module jitterFifo (
    input  logic              clk,
    input  logic              reset,
    input  logic              pnBitEn,
    input  logic              pnBit,
    input  bertPkg::divider_t drainRate,
    pnCtrlIf.fifo             pnCtrl,
    output logic              credit,
    output logic              smoothBitEn,
    output logic              smoothBit
);

    logic                mem [`BERT_FIFO_DEPTH];
    bertPkg::fifoPtr_t   wrPtr;
    bertPkg::fifoPtr_t   rdPtr;
    bertPkg::fifoCount_t fill;
    bertPkg::divider_t   drainCount;
    logic                running;
    logic                drainTick;
    logic                doRead;

    assign drainTick = running && (drainCount >= drainRate);
    assign doRead    = drainTick && (fill != '0);

    assign pnCtrl.fifoRunning = running;

    always_ff @(posedge clk) begin
        if (pnBitEn) begin
            mem[wrPtr] <= pnBit;
        end
        if (doRead) begin
            smoothBit <= mem[rdPtr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            fill        <= '0;
            drainCount  <= '0;
            running     <= 1'b0;
            smoothBitEn <= 1'b0;
            credit      <= 1'b0;
        end else begin
            smoothBitEn <= doRead;
            credit      <= doRead;
            if (pnBitEn) begin
                wrPtr <= wrPtr + bertPkg::fifoPtr_t'(1);
            end
            if (doRead) begin
                rdPtr <= rdPtr + bertPkg::fifoPtr_t'(1);
            end
            case ({pnBitEn, doRead})
                2'b10:   fill <= fill + bertPkg::fifoCount_t'(1);
                2'b01:   fill <= fill - bertPkg::fifoCount_t'(1);
                default: fill <= fill;
            endcase
            // Start at half full, stop once empty
            if (fill == '0) begin
                running <= 1'b0;
            end else if (fill >= (`BERT_FIFO_DEPTH / 2)) begin
                running <= 1'b1;
            end
            if (!running || doRead) begin
                drainCount <= '0;
            end else if (!drainTick) begin
                drainCount <= drainCount + bertPkg::divider_t'(1);
            end
        end
    end

    noOverflow: assert property (@(posedge clk) disable iff (reset)
        !(pnBitEn && (fill == `BERT_FIFO_DEPTH)))
        else $error("Write into a full FIFO");

endmodule

`default_nettype wire

// File: pnGenerator.sv
`timescale 1ns/1ns
`default_nettype none
`include "bert_settings.svh"

module pnGenerator (
    input  logic clk,
    input  logic reset,
    pnCtrlIf.gen pnCtrl,
    input  logic credit,
    output logic pnBitEn,
    output logic pnBit
);

    bertPkg::divider_t   rateCount;
    bertPkg::fifoCount_t credits;
    bertPkg::pnState_t   pnState;
    logic                injectPending;
    logic                rateDone;
    logic                emit;
    logic                feedback;

    // x^15 + x^14 + 1 with the newest bit in position 0
    assign feedback = pnState[14] ^ pnState[13];
    assign rateDone = rateCount >= pnCtrl.pnRate;
    assign emit     = pnCtrl.pnEnable && rateDone && (credits != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            rateCount     <= '0;
            credits       <= bertPkg::fifoCount_t'(`BERT_FIFO_DEPTH);
            pnState       <= '1;
            injectPending <= 1'b0;
            pnBitEn       <= 1'b0;
        end else begin
            pnBitEn <= emit;
            if (!pnCtrl.pnEnable || emit) begin
                rateCount <= '0;
            end else if (!rateDone) begin
                rateCount <= rateCount + bertPkg::divider_t'(1);
            end
            // One credit spent per symbol, one back per drained symbol
            case ({emit, credit})
                2'b10:   credits <= credits - bertPkg::fifoCount_t'(1);
                2'b01:   credits <= credits + bertPkg::fifoCount_t'(1);
                default: credits <= credits;
            endcase
            if (emit) begin
                pnState       <= {pnState[13:0], feedback};
                injectPending <= pnCtrl.injectError;
            end else if (pnCtrl.injectError) begin
                injectPending <= 1'b1;
            end
        end
    end

    // Error flips the output only and the sequence itself runs on
    always_ff @(posedge clk) begin
        if (emit) begin
            pnBit <= feedback ^ injectPending;
        end
    end

    creditBound: assert property (@(posedge clk) disable iff (reset)
        credits <= `BERT_FIFO_DEPTH)
        else $error("Credit count above FIFO depth");

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# Build and run the BERT testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module bertTb \
    -f sources.f -o bertSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/bertSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi

exit 0

// File: sources.f
+incdir+.
bertPkg.sv
bertIfs.sv
bertRegs.sv
pnGenerator.sv
jitterFifo.sv
bertRouter.sv
bertChecker.sv
bertTop.sv
bertTb.sv
